//--- files.f
+incdir+hw
hw/isa_pkg.sv
hw/core_pkg.sv
hw/free_list.sv
hw/map_entry.sv
hw/rename_lookup.sv
hw/rename_unit.sv
testbench/rename_checker.sv
testbench/rename_tb.sv

//--- hw/core_pkg.sv
// Physical tag type, free-list pointer type and free-list depth

`include "rename_macros.svh"

package core_pkg;

    ////////////////////////////////////////////////////////////////////////
    // Physical registers
    ////////////////////////////////////////////////////////////////////////

    // Tag of one physical register
    typedef logic [`PREG_BITS-1:0] preg_t;

    ////////////////////////////////////////////////////////////////////////
    // Free list
    ////////////////////////////////////////////////////////////////////////

    // Head and tail pointers carry a wrap bit above the index
    typedef logic [`FREE_PTR_BITS-1:0] free_ptr_t;

    // Tags not covered by the reset mapping
    localparam int FREE_DEPTH = `NUM_PREGS - `NUM_LREGS;

endpackage

//--- hw/free_list.sv
// Circular queue of free physical tags with allocate at head and release at tail

`timescale 1ns/1ns

`include "rename_macros.svh"

module free_list (
    input  logic            clk_i,
    input  logic            rstn_i,
    // Pop the head tag
    input  logic            alloc_i,
    // Push a tag freed at commit
    input  logic            release_i,
    input  core_pkg::preg_t release_preg_i,
    // Tag offered to the next renamed destination
    output core_pkg::preg_t new_preg_o,
    output logic            empty_o
);

    localparam int IDX_BITS = $clog2(core_pkg::FREE_DEPTH);

    ////////////////////////////////////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////////////////////////////////////

    core_pkg::preg_t     free_tags_q [core_pkg::FREE_DEPTH];
    core_pkg::free_ptr_t head_q;
    core_pkg::free_ptr_t tail_q;
    core_pkg::free_ptr_t count;
    logic [IDX_BITS-1:0] head_idx;
    logic [IDX_BITS-1:0] tail_idx;
    logic                do_pop;

    // Wrap bit is dropped when addressing the array
    assign head_idx = head_q[IDX_BITS-1:0];
    assign tail_idx = tail_q[IDX_BITS-1:0];

    // Entries between head and tail with the wrap bit telling full from empty
    assign count   = tail_q - head_q;
    assign empty_o = (count == '0);

    assign new_preg_o = free_tags_q[head_idx];

    // Never pop past the tail
    assign do_pop = alloc_i && !empty_o;

    ////////////////////////////////////////////////////////////////////////
    // Pointer update
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            head_q <= '0;
            // Queue starts full
            tail_q <= core_pkg::free_ptr_t'(core_pkg::FREE_DEPTH);
        end else begin
            if (do_pop) begin
                head_q <= head_q + 1'b1;
            end
            if (release_i) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Tag array
    ////////////////////////////////////////////////////////////////////////

    // Tags above the identity mapping are free after reset
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < core_pkg::FREE_DEPTH; i++) begin
                free_tags_q[i] <= core_pkg::preg_t'(`NUM_LREGS + i);
            end
        end else if (release_i) begin
            // Visible at the head one cycle later at the earliest
            free_tags_q[tail_idx] <= release_preg_i;
        end
    end

endmodule

//--- hw/isa_pkg.sv
// Architectural register index type and the hard-wired zero register

`include "rename_macros.svh"

package isa_pkg;

    ////////////////////////////////////////////////////////////////////////
    // Architectural registers
    ////////////////////////////////////////////////////////////////////////

    // Index of an integer register as seen by software
    typedef logic [`LREG_BITS-1:0] lreg_t;

    // x0 reads as zero and is never renamed
    localparam lreg_t ZERO_REG = '0;

endpackage

//--- hw/map_entry.sv
// One rename table entry holding an architectural register's tag and ready bit

`timescale 1ns/1ns

module map_entry #(
    parameter int ENTRY_INDEX = 0
) (
    input  logic            clk_i,
    input  logic            rstn_i,
    // Destination update from the rename stage
    input  logic            write_i,
    input  isa_pkg::lreg_t  write_lreg_i,
    input  core_pkg::preg_t new_preg_i,
    // ALU writeback
    input  logic            wb1_valid_i,
    input  isa_pkg::lreg_t  wb1_lreg_i,
    input  core_pkg::preg_t wb1_preg_i,
    // Memory writeback
    input  logic            wb2_valid_i,
    input  isa_pkg::lreg_t  wb2_lreg_i,
    input  core_pkg::preg_t wb2_preg_i,
    output core_pkg::preg_t preg_o,
    output logic            ready_o
);

    localparam isa_pkg::lreg_t MY_LREG  = isa_pkg::lreg_t'(ENTRY_INDEX);
    localparam logic           IS_ZERO  = (MY_LREG == isa_pkg::ZERO_REG);

    core_pkg::preg_t preg_q;
    logic            ready_q;
    logic            own_write;
    logic            wb1_hit;
    logic            wb2_hit;
    logic            wake_up;

    // x0 keeps its reset mapping forever
    assign own_write = write_i && (write_lreg_i == MY_LREG) && !IS_ZERO;

    // Writeback must name this register and the tag it still holds
    assign wb1_hit = wb1_valid_i && (wb1_lreg_i == MY_LREG) && (wb1_preg_i == preg_q);
    assign wb2_hit = wb2_valid_i && (wb2_lreg_i == MY_LREG) && (wb2_preg_i == preg_q);
    assign wake_up = wb1_hit || wb2_hit;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            preg_q  <= core_pkg::preg_t'(ENTRY_INDEX);
            ready_q <= 1'b1;
        end else if (own_write) begin
            // New producer is still in flight
            preg_q  <= new_preg_i;
            ready_q <= 1'b0;
        end else if (wake_up) begin
            ready_q <= 1'b1;
        end
    end

    assign preg_o  = preg_q;
    // Bypass a writeback landing in the lookup cycle
    assign ready_o = ready_q || wake_up;

endmodule

//--- hw/rename_lookup.sv
// Rename lookup with source and old destination select, result register and snoop

`timescale 1ns/1ns

`include "rename_macros.svh"

module rename_lookup (
    input  logic                             clk_i,
    input  logic                             rstn_i,
    input  logic                             accept_i,
    input  logic                             alloc_i,
    input  isa_pkg::lreg_t                   rs1_i,
    input  isa_pkg::lreg_t                   rs2_i,
    input  isa_pkg::lreg_t                   rd_i,
    // Current state of every map entry
    input  core_pkg::preg_t [`NUM_LREGS-1:0] map_preg_i,
    input  logic [`NUM_LREGS-1:0]            map_ready_i,
    input  core_pkg::preg_t                  new_preg_i,
    // Writeback tags for the output-cycle snoop
    input  logic                             wb1_valid_i,
    input  core_pkg::preg_t                  wb1_preg_i,
    input  logic                             wb2_valid_i,
    input  core_pkg::preg_t                  wb2_preg_i,
    output logic                             rename_valid_o,
    output core_pkg::preg_t                  prs1_o,
    output core_pkg::preg_t                  prs2_o,
    output logic                             rdy1_o,
    output logic                             rdy2_o,
    output core_pkg::preg_t                  prd_o,
    output core_pkg::preg_t                  old_prd_o
);

    ////////////////////////////////////////////////////////////////////////
    // Lookup cycle
    ////////////////////////////////////////////////////////////////////////

    core_pkg::preg_t old_prd_d;
    core_pkg::preg_t prd_d;

    // Tags are reported as 0 when nothing was allocated
    assign old_prd_d = alloc_i ? map_preg_i[rd_i] : '0;
    assign prd_d     = alloc_i ? new_preg_i : '0;

    ////////////////////////////////////////////////////////////////////////
    // Result register
    ////////////////////////////////////////////////////////////////////////

    logic            valid_q;
    isa_pkg::lreg_t  rs1_q;
    isa_pkg::lreg_t  rs2_q;
    core_pkg::preg_t prs1_q;
    core_pkg::preg_t prs2_q;
    logic            rdy1_q;
    logic            rdy2_q;
    core_pkg::preg_t prd_q;
    core_pkg::preg_t old_prd_q;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept_i;
        end
    end

    // Sources see the table before this instruction's own destination write
    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            rs1_q     <= rs1_i;
            rs2_q     <= rs2_i;
            prs1_q    <= map_preg_i[rs1_i];
            prs2_q    <= map_preg_i[rs2_i];
            rdy1_q    <= map_ready_i[rs1_i];
            rdy2_q    <= map_ready_i[rs2_i];
            prd_q     <= prd_d;
            old_prd_q <= old_prd_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Output cycle snoop
    ////////////////////////////////////////////////////////////////////////

    logic snoop_rs1;
    logic snoop_rs2;

    // Physical tag match with x0 excluded by its architectural index
    assign snoop_rs1 = (rs1_q != isa_pkg::ZERO_REG) &&
                       ((wb1_valid_i && (wb1_preg_i == prs1_q)) ||
                        (wb2_valid_i && (wb2_preg_i == prs1_q)));
    assign snoop_rs2 = (rs2_q != isa_pkg::ZERO_REG) &&
                       ((wb1_valid_i && (wb1_preg_i == prs2_q)) ||
                        (wb2_valid_i && (wb2_preg_i == prs2_q)));

    assign rename_valid_o = valid_q;
    assign prs1_o         = prs1_q;
    assign prs2_o         = prs2_q;
    assign rdy1_o         = rdy1_q || snoop_rs1;
    assign rdy2_o         = rdy2_q || snoop_rs2;
    assign prd_o          = prd_q;
    assign old_prd_o      = old_prd_q;

endmodule

//--- hw/rename_macros.svh
// Register counts, tag widths and free-list pointer width for the rename path

`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Architectural register file
////////////////////////////////////////////////////////////////////////////

// Integer registers visible to software
`define NUM_LREGS 32
`define LREG_BITS 5

////////////////////////////////////////////////////////////////////////////
// Physical register file
////////////////////////////////////////////////////////////////////////////

`define NUM_PREGS 64
`define PREG_BITS 6

// Index into the free list plus one wrap bit
`define FREE_PTR_BITS 6

`endif

//--- hw/rename_unit.sv
// Rename unit top with free list, generated map entries and rename lookup

`timescale 1ns/1ns

`include "rename_macros.svh"

module rename_unit (
    input  logic            clk_i,
    input  logic            rstn_i,
    // Rename request
    input  logic            rename_valid_i,
    input  isa_pkg::lreg_t  rs1_i,
    input  isa_pkg::lreg_t  rs2_i,
    input  isa_pkg::lreg_t  rd_i,
    input  logic            rd_we_i,
    // ALU writeback
    input  logic            wb1_valid_i,
    input  isa_pkg::lreg_t  wb1_lreg_i,
    input  core_pkg::preg_t wb1_preg_i,
    // Memory writeback
    input  logic            wb2_valid_i,
    input  isa_pkg::lreg_t  wb2_lreg_i,
    input  core_pkg::preg_t wb2_preg_i,
    // Commit returns the previous destination tag
    input  logic            commit_valid_i,
    input  core_pkg::preg_t commit_old_prd_i,
    output logic            rename_ready_o,
    // Rename result
    output logic            rename_valid_o,
    output core_pkg::preg_t prs1_o,
    output core_pkg::preg_t prs2_o,
    output logic            rdy1_o,
    output logic            rdy2_o,
    output core_pkg::preg_t prd_o,
    output core_pkg::preg_t old_prd_o
);

    ////////////////////////////////////////////////////////////////////////
    // Request control
    ////////////////////////////////////////////////////////////////////////

    logic                             accept;
    logic                             alloc;
    logic                             free_list_empty;
    core_pkg::preg_t                  new_preg;
    core_pkg::preg_t [`NUM_LREGS-1:0] map_preg;
    logic [`NUM_LREGS-1:0]            map_ready;

    assign rename_ready_o = !free_list_empty;
    assign accept         = rename_valid_i && rename_ready_o;

    // Only real destinations consume a tag
    assign alloc = accept && rd_we_i && (rd_i != isa_pkg::ZERO_REG);

    ////////////////////////////////////////////////////////////////////////
    // Free list
    ////////////////////////////////////////////////////////////////////////

    free_list free_list_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .alloc_i        (alloc),
        .release_i      (commit_valid_i),
        .release_preg_i (commit_old_prd_i),
        .new_preg_o     (new_preg),
        .empty_o        (free_list_empty)
    );

    ////////////////////////////////////////////////////////////////////////
    // Rename table
    ////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `NUM_LREGS; i++) begin : gen_map
        map_entry #(
            .ENTRY_INDEX (i)
        ) map_entry_inst (
            .clk_i        (clk_i),
            .rstn_i       (rstn_i),
            .write_i      (alloc),
            .write_lreg_i (rd_i),
            .new_preg_i   (new_preg),
            .wb1_valid_i  (wb1_valid_i),
            .wb1_lreg_i   (wb1_lreg_i),
            .wb1_preg_i   (wb1_preg_i),
            .wb2_valid_i  (wb2_valid_i),
            .wb2_lreg_i   (wb2_lreg_i),
            .wb2_preg_i   (wb2_preg_i),
            .preg_o       (map_preg[i]),
            .ready_o      (map_ready[i])
        );
    end

    ////////////////////////////////////////////////////////////////////////
    // Lookup and result stage
    ////////////////////////////////////////////////////////////////////////

    rename_lookup rename_lookup_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .accept_i       (accept),
        .alloc_i        (alloc),
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .rd_i           (rd_i),
        .map_preg_i     (map_preg),
        .map_ready_i    (map_ready),
        .new_preg_i     (new_preg),
        .wb1_valid_i    (wb1_valid_i),
        .wb1_preg_i     (wb1_preg_i),
        .wb2_valid_i    (wb2_valid_i),
        .wb2_preg_i     (wb2_preg_i),
        .rename_valid_o (rename_valid_o),
        .prs1_o         (prs1_o),
        .prs2_o         (prs2_o),
        .rdy1_o         (rdy1_o),
        .rdy2_o         (rdy2_o),
        .prd_o          (prd_o),
        .old_prd_o      (old_prd_o)
    );

endmodule

//--- testbench/rename_checker.sv
// Reference model of the rename path, expected-result function and result comparison

`timescale 1ns/1ns

module rename_checker (
    input logic            clk_i,
    input logic            rstn_i,
    // Request and writeback traffic seen at the DUT inputs
    input logic            req_valid_i,
    input isa_pkg::lreg_t  rs1_i,
    input isa_pkg::lreg_t  rs2_i,
    input isa_pkg::lreg_t  rd_i,
    input logic            rd_we_i,
    input logic            wb1_valid_i,
    input isa_pkg::lreg_t  wb1_lreg_i,
    input core_pkg::preg_t wb1_preg_i,
    input logic            wb2_valid_i,
    input isa_pkg::lreg_t  wb2_lreg_i,
    input core_pkg::preg_t wb2_preg_i,
    input logic            commit_valid_i,
    input core_pkg::preg_t commit_old_prd_i,
    // DUT responses
    input logic            dut_ready_i,
    input logic            dut_valid_i,
    input core_pkg::preg_t dut_prs1_i,
    input core_pkg::preg_t dut_prs2_i,
    input logic            dut_rdy1_i,
    input logic            dut_rdy2_i,
    input core_pkg::preg_t dut_prd_i,
    input core_pkg::preg_t dut_old_prd_i
);

    localparam int NUM_LREGS  = 32;
    localparam int FIRST_FREE = 32;
    localparam int ZERO_LREG  = 0;

    typedef struct packed {
        core_pkg::preg_t prs1;
        core_pkg::preg_t prs2;
        logic            rdy1;
        logic            rdy2;
        core_pkg::preg_t prd;
        core_pkg::preg_t old_prd;
    } result_t;

    core_pkg::preg_t model_map [NUM_LREGS];
    logic            model_ready [NUM_LREGS];
    core_pkg::preg_t model_free [$];
    result_t         exp_res;
    isa_pkg::lreg_t  exp_rs1;
    isa_pkg::lreg_t  exp_rs2;
    logic            exp_valid;
    int              check_count = 0;
    int              error_count = 0;

    // Writeback naming this register and the tag it currently holds
    function automatic logic woken(input isa_pkg::lreg_t lreg);
        return (wb1_valid_i && wb1_lreg_i == lreg && wb1_preg_i == model_map[lreg]) ||
               (wb2_valid_i && wb2_lreg_i == lreg && wb2_preg_i == model_map[lreg]);
    endfunction

    // Output-cycle snoop matches on the physical tag only
    function automatic logic snooped(input isa_pkg::lreg_t rs, input core_pkg::preg_t prs);
        return (rs != ZERO_LREG) &&
               ((wb1_valid_i && wb1_preg_i == prs) || (wb2_valid_i && wb2_preg_i == prs));
    endfunction

    function automatic result_t expected_rename(input isa_pkg::lreg_t rs1,
                                                input isa_pkg::lreg_t rs2,
                                                input isa_pkg::lreg_t rd,
                                                input logic we);
        result_t res;
        logic    alloc;
        alloc       = we && (rd != ZERO_LREG);
        res.prs1    = model_map[rs1];
        res.prs2    = model_map[rs2];
        res.rdy1    = model_ready[rs1] || woken(rs1);
        res.rdy2    = model_ready[rs2] || woken(rs2);
        res.prd     = alloc ? model_free[0] : '0;
        res.old_prd = alloc ? model_map[rd] : '0;
        return res;
    endfunction

    task automatic compare(input string name, input logic [7:0] expected,
                           input logic [7:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s expected 0x%h got 0x%h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    task automatic reset_model();
        model_free.delete();
        for (int i = 0; i < NUM_LREGS; i++) begin
            model_map[i]   = core_pkg::preg_t'(i);
            model_ready[i] = 1'b1;
            model_free.push_back(core_pkg::preg_t'(FIRST_FREE + i));
        end
        exp_valid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare at every rising edge and advance the model
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin : compare_proc
        logic accept;
        if (!rstn_i) begin
            reset_model();
        end else begin
            compare("rename_ready_o", model_free.size() != 0, dut_ready_i);
            compare("rename_valid_o", exp_valid, dut_valid_i);
            if (exp_valid && dut_valid_i) begin
                compare("prs1_o", exp_res.prs1, dut_prs1_i);
                compare("prs2_o", exp_res.prs2, dut_prs2_i);
                compare("rdy1_o", exp_res.rdy1 || snooped(exp_rs1, exp_res.prs1), dut_rdy1_i);
                compare("rdy2_o", exp_res.rdy2 || snooped(exp_rs2, exp_res.prs2), dut_rdy2_i);
                compare("prd_o", exp_res.prd, dut_prd_i);
                compare("old_prd_o", exp_res.old_prd, dut_old_prd_i);
            end
            accept    = req_valid_i && (model_free.size() != 0);
            exp_valid = accept;
            if (accept) begin
                exp_res = expected_rename(rs1_i, rs2_i, rd_i, rd_we_i);
                exp_rs1 = rs1_i;
                exp_rs2 = rs2_i;
            end
            // A destination write in the same edge overrides the wake-up
            if (woken(wb1_lreg_i)) begin
                model_ready[wb1_lreg_i] = 1'b1;
            end
            if (woken(wb2_lreg_i)) begin
                model_ready[wb2_lreg_i] = 1'b1;
            end
            if (accept && rd_we_i && rd_i != ZERO_LREG) begin
                model_map[rd_i]   = model_free.pop_front();
                model_ready[rd_i] = 1'b0;
            end
            if (commit_valid_i) begin
                model_free.push_back(commit_old_prd_i);
            end
        end
    end

endmodule

//--- testbench/rename_tb.sv
// Testbench top with clock, reset, directed and random rename stimulus and the DUT

`timescale 1ns/1ns

module rename_tb;

    localparam int TIMEOUT_CYCLES = 100;
    localparam int RANDOM_CYCLES  = 300;

    logic            clk_i;
    logic            rstn_i;
    logic            rename_valid_i;
    isa_pkg::lreg_t  rs1_i;
    isa_pkg::lreg_t  rs2_i;
    isa_pkg::lreg_t  rd_i;
    logic            rd_we_i;
    logic            wb1_valid_i;
    isa_pkg::lreg_t  wb1_lreg_i;
    core_pkg::preg_t wb1_preg_i;
    logic            wb2_valid_i;
    isa_pkg::lreg_t  wb2_lreg_i;
    core_pkg::preg_t wb2_preg_i;
    logic            commit_valid_i;
    core_pkg::preg_t commit_old_prd_i;
    logic            rename_ready_o;
    logic            rename_valid_o;
    core_pkg::preg_t prs1_o;
    core_pkg::preg_t prs2_o;
    logic            rdy1_o;
    logic            rdy2_o;
    core_pkg::preg_t prd_o;
    core_pkg::preg_t old_prd_o;

    logic [31:0]     rng_state;
    int              timeout_count;
    int              errors_before;
    core_pkg::preg_t new_tag;
    core_pkg::preg_t old_tag;
    core_pkg::preg_t stale_tag;
    // Issued {lreg, tag, old tag} awaiting writeback and old tags awaiting commit
    logic [16:0]     pending_q [$];
    core_pkg::preg_t commit_q [$];

    rename_unit dut_i (.*);

    rename_checker checker_i (
        .clk_i (clk_i), .rstn_i (rstn_i),
        .req_valid_i (rename_valid_i), .rs1_i (rs1_i), .rs2_i (rs2_i),
        .rd_i (rd_i), .rd_we_i (rd_we_i),
        .wb1_valid_i (wb1_valid_i), .wb1_lreg_i (wb1_lreg_i), .wb1_preg_i (wb1_preg_i),
        .wb2_valid_i (wb2_valid_i), .wb2_lreg_i (wb2_lreg_i), .wb2_preg_i (wb2_preg_i),
        .commit_valid_i (commit_valid_i), .commit_old_prd_i (commit_old_prd_i),
        .dut_ready_i (rename_ready_o), .dut_valid_i (rename_valid_o),
        .dut_prs1_i (prs1_o), .dut_prs2_i (prs2_o), .dut_rdy1_i (rdy1_o),
        .dut_rdy2_i (rdy2_o), .dut_prd_i (prd_o), .dut_old_prd_i (old_prd_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic clear_inputs();
        rename_valid_i   = 1'b0;
        rs1_i            = '0;
        rs2_i            = '0;
        rd_i             = '0;
        rd_we_i          = 1'b0;
        wb1_valid_i      = 1'b0;
        wb1_lreg_i       = '0;
        wb1_preg_i       = '0;
        wb2_valid_i      = 1'b0;
        wb2_lreg_i       = '0;
        wb2_preg_i       = '0;
        commit_valid_i   = 1'b0;
        commit_old_prd_i = '0;
    endtask

    task automatic apply_reset();
        rstn_i = 1'b0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
    endtask

    // Holds the request until ready and returns in the output cycle
    task automatic rename_req(input isa_pkg::lreg_t rs1, input isa_pkg::lreg_t rs2,
                              input isa_pkg::lreg_t rd, input logic we,
                              output core_pkg::preg_t prd, output core_pkg::preg_t old_prd);
        int waited;
        waited = 0;
        while (!rename_ready_o && waited < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            waited++;
        end
        if (!rename_ready_o) begin
            $display("Timeout: rename_ready_o stayed low for %0d cycles", waited);
            timeout_count++;
        end
        rename_valid_i = 1'b1;
        rs1_i          = rs1;
        rs2_i          = rs2;
        rd_i           = rd;
        rd_we_i        = we;
        @(negedge clk_i);
        rename_valid_i = 1'b0;
        prd            = prd_o;
        old_prd        = old_prd_o;
    endtask

    task automatic drive_wb(input int port, input isa_pkg::lreg_t lreg,
                            input core_pkg::preg_t preg);
        if (port == 1) begin
            wb1_valid_i = 1'b1;
            wb1_lreg_i  = lreg;
            wb1_preg_i  = preg;
        end else begin
            wb2_valid_i = 1'b1;
            wb2_lreg_i  = lreg;
            wb2_preg_i  = preg;
        end
        @(negedge clk_i);
        wb1_valid_i = 1'b0;
        wb2_valid_i = 1'b0;
    endtask

    task automatic commit_tag(input core_pkg::preg_t tag);
        commit_valid_i   = 1'b1;
        commit_old_prd_i = tag;
        @(negedge clk_i);
        commit_valid_i   = 1'b0;
    endtask

    task automatic finish_test(input string name);
        int waited;
        int errors_now;
        waited = 0;
        while (rename_valid_o && waited < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            waited++;
        end
        if (rename_valid_o) begin
            $display("Timeout: rename_valid_o stayed high after the last request");
            timeout_count++;
        end
        errors_now = checker_i.error_count + timeout_count;
        $display("Test %s finished with %0d errors", name, errors_now - errors_before);
        errors_before = errors_now;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Random traffic with one decision per falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_random_traffic();
        logic [31:0]    r;
        logic [16:0]    entry;
        isa_pkg::lreg_t last_rd;
        last_rd = '0;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            rng_state = xorshift(rng_state);
            r         = rng_state;
            // Tag issued by the request of the previous cycle
            if (rename_valid_o && prd_o != '0) begin
                pending_q.push_back({last_rd, prd_o, old_prd_o});
            end
            rename_valid_i = rename_ready_o && r[0];
            rd_we_i        = (r[2:1] != 2'b00);
            rs1_i          = r[8:4];
            rs2_i          = r[13:9];
            rd_i           = r[18:14];
            last_rd        = r[18:14];
            wb1_valid_i    = 1'b0;
            wb2_valid_i    = 1'b0;
            commit_valid_i = 1'b0;
            if (pending_q.size() != 0 && r[19]) begin
                entry = pending_q.pop_front();
                commit_q.push_back(entry[5:0]);
                if (r[20]) begin
                    wb1_valid_i = 1'b1;
                    wb1_lreg_i  = entry[16:12];
                    wb1_preg_i  = entry[11:6];
                end else begin
                    wb2_valid_i = 1'b1;
                    wb2_lreg_i  = entry[16:12];
                    wb2_preg_i  = entry[11:6];
                end
            end
            if (commit_q.size() != 0 && r[21]) begin
                commit_valid_i   = 1'b1;
                commit_old_prd_i = commit_q.pop_front();
            end
            @(negedge clk_i);
        end
        clear_inputs();
    endtask

    initial begin
        rstn_i        = 1'b0;
        rng_state     = 32'd72233;
        timeout_count = 0;
        errors_before = 0;
        clear_inputs();
        apply_reset();

        for (int i = 0; i < 8; i++) begin
            rename_req(i, 31 - i, i, 1'b0, new_tag, old_tag);
        end
        finish_test("1 reset mapping");

        rename_req(1, 2, 3, 1'b1, new_tag, old_tag);
        rename_req(3, 4, 3, 1'b1, new_tag, old_tag);
        rename_req(3, 0, 0, 1'b1, new_tag, old_tag);
        rename_req(5, 5, 5, 1'b1, new_tag, old_tag);
        finish_test("2 allocation and dependence");

        drive_wb(1, 3, 6'd33);
        rename_req(3, 0, 0, 1'b0, new_tag, old_tag);
        drive_wb(2, 5, 6'd34);
        rename_req(5, 5, 0, 1'b0, new_tag, old_tag);
        rename_req(0, 0, 6, 1'b1, new_tag, old_tag);
        rename_req(6, 6, 0, 1'b0, stale_tag, old_tag);
        // Writeback lands in the output cycle of the lookup above
        drive_wb(2, 6, new_tag);
        rename_req(0, 0, 7, 1'b1, stale_tag, old_tag);
        rename_req(0, 0, 7, 1'b1, new_tag, old_tag);
        drive_wb(1, 7, stale_tag);
        rename_req(7, 0, 0, 1'b0, new_tag, old_tag);
        finish_test("3 wake-up and snoop");

        apply_reset();
        for (int i = 0; i < 32; i++) begin
            rename_req(1, 2, (i % 31) + 1, 1'b1, new_tag, old_tag);
        end
        fork
            rename_req(1, 2, 9, 1'b1, new_tag, stale_tag);
            begin
                // Previous mapping of x1 returned by the last allocation
                commit_tag(old_tag);
                commit_tag(6'd5);
            end
        join
        rename_req(3, 4, 10, 1'b1, new_tag, old_tag);
        finish_test("4 exhaustion and release");

        apply_reset();
        run_random_traffic();
        finish_test("5 random traffic");

        $display("Summary: 5 tests, %0d checks, %0d errors, %0d timeouts",
                 checker_i.check_count, checker_i.error_count, timeout_count);
        if (checker_i.error_count + timeout_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
